//--- flist.f
+incdir+source
source/mem_wr_pkg.sv
source/req_fifo.sv
source/ack_align.sv
source/mem_wr_aggregate.sv
source/slice_mem.sv
source/mem_wr_subsys.sv
verif/mem_wr_subsys_tb.sv

//--- verif/mem_wr_subsys_tb.sv
/* table-driven testbench for the wide-write subsystem. writes go through the wide port,
   reads come back through the top-level read port and are compared with a reference memory. */
`timescale 1ns/1ps
`include "mem_wr_settings.svh"

module mem_wr_subsys_tb;
    import mem_wr_pkg::*;

    localparam int N        = `MW_N_SLICES;
    localparam int SW       = `MW_SLICE_WID;
    localparam int WIDE_W   = N * SW;
    localparam int NUM_OPS  = 27;
    localparam int WD_LIMIT = NUM_OPS * 40 + 100; // watchdog limit in cycles.

    typedef struct packed {
        logic                    is_read;
        logic                    rnd;   // data comes from $random when set.
        logic                    burst; // next op follows without waiting for acks.
        logic [`MW_ADDR_WID-1:0] addr;
        logic [WIDE_W-1:0]       data;
    } op_t;

    logic                      from_controller;
    logic                      rst_n;
    logic                      wr_req;
    wide_req_t                 wr;
    logic                      wr_rdy;
    logic                      wr_ack;
    addr_t                     rd_addr;
    wide_word_u                rd_data;
    slice_status_t [N-1:0]     status;

    op_t               ops [NUM_OPS];
    logic [WIDE_W-1:0] ref_mem [2**`MW_ADDR_WID];
    integer            seed;
    int                errors;
    int                checks;
    int                accept_count;
    int                ack_count;
    int                writes_sent;
    int                stall_count;

    mem_wr_subsys mem_wr_subsys_i (
        .from_controller ( from_controller ),
        .rst_n           ( rst_n ),
        .wr_req          ( wr_req ),
        .wr              ( wr ),
        .wr_rdy          ( wr_rdy ),
        .wr_ack          ( wr_ack ),
        .rd_addr         ( rd_addr ),
        .rd_data         ( rd_data ),
        .status          ( status )
    );

    always #50 from_controller = ~from_controller;

    task automatic set_entry(input int idx, input logic is_read, input int addr,
                             input logic [WIDE_W-1:0] data, input logic rnd,
                             input logic burst);
        ops[idx] = '{is_read: is_read, rnd: rnd, burst: burst,
                     addr: addr[`MW_ADDR_WID-1:0], data: data};
    endtask

    task automatic build_table();
        set_entry(0, 1'b0, 5, 64'h0123_4567_89ab_cdef, 1'b0, 1'b0);
        set_entry(1, 1'b1, 5, '0, 1'b0, 1'b0);
        set_entry(2, 1'b0, 6, 64'hfedc_ba98_7654_3210, 1'b0, 1'b0);
        set_entry(3, 1'b1, 6, '0, 1'b0, 1'b0);
        // eight back to back writes, enough to fill the slow slice FIFOs.
        for (int k = 0; k < 8; k++) begin
            set_entry(4 + k, 1'b0, 16 + k, '0, 1'b1, k != 7);
        end
        set_entry(12, 1'b1, 16, '0, 1'b0, 1'b0);
        set_entry(13, 1'b1, 17, '0, 1'b0, 1'b0);
        set_entry(14, 1'b1, 20, '0, 1'b0, 1'b0);
        set_entry(15, 1'b1, 23, '0, 1'b0, 1'b0);
        set_entry(16, 1'b0, 40, '0, 1'b1, 1'b1); // overwrites within one burst.
        set_entry(17, 1'b0, 40, '0, 1'b1, 1'b1);
        set_entry(18, 1'b0, 41, '0, 1'b1, 1'b1);
        set_entry(19, 1'b0, 40, 64'h5555_aaaa_3c3c_c3c3, 1'b0, 1'b1);
        set_entry(20, 1'b0, 41, '0, 1'b1, 1'b0);
        set_entry(21, 1'b1, 40, '0, 1'b0, 1'b0);
        set_entry(22, 1'b1, 41, '0, 1'b0, 1'b0);
        set_entry(23, 1'b1, 5, '0, 1'b0, 1'b0);
        set_entry(24, 1'b0, 63, 64'hffff_0000_ffff_0000, 1'b0, 1'b0);
        set_entry(25, 1'b1, 63, '0, 1'b0, 1'b0);
        set_entry(26, 1'b1, 22, '0, 1'b0, 1'b0);
    endtask

    // called on a falling edge; returns on the falling edge after acceptance.
    task automatic write_word(input addr_t addr, input logic [WIDE_W-1:0] data);
        wr_req         = 1'b1;
        wr.addr        = addr;
        wr.data.flat   = data;
        while (!wr_rdy) @(negedge from_controller); // held under back-pressure.
        @(negedge from_controller);
        wr_req        = 1'b0;
        ref_mem[addr] = data;
        writes_sent++;
    endtask

    task automatic wait_drain();
        while (ack_count != accept_count) @(negedge from_controller);
    endtask

    task automatic read_check(input addr_t addr);
        logic [WIDE_W-1:0] exp;
        wait_drain();
        exp     = ref_mem[addr];
        rd_addr = addr;
        @(negedge from_controller);
        checks++;
        assert (rd_data.flat === exp) else begin
            errors++;
            $display("Error: %0d ns: address %0d read %h, expected %h",
                     $time, addr, rd_data.flat, exp);
        end
        for (int s = 0; s < N; s++) begin
            checks++;
            assert (rd_data.slice[s] === exp[s*SW +: SW]) else begin
                errors++;
                $display("Error: %0d ns: address %0d slice %0d read %h, expected %h",
                         $time, addr, s, rd_data.slice[s], exp[s*SW +: SW]);
            end
        end
    endtask

    task automatic check_idle_status();
        for (int s = 0; s < N; s++) begin
            checks++;
            assert (!status[s].req_pending && !status[s].resp_pending) else begin
                errors++;
                $display("Error: %0d ns: slice %0d still pending after drain (status %b)",
                         $time, s, status[s]);
            end
        end
    endtask

    // acceptance and wide ack as seen at each rising edge.
    always @(posedge from_controller) begin
        if (rst_n) begin
            if (wr_ack) begin
                ack_count++;
                assert (ack_count <= accept_count) else begin
                    errors++;
                    $display("Error: %0d ns: %0d wide acks for %0d accepted writes",
                             $time, ack_count, accept_count);
                end
            end
            if (wr_req && wr_rdy) accept_count++;
            if (wr_req && !wr_rdy) stall_count++;
            for (int s = 0; s < N; s++) begin
                assert (!status[s].req_oflow && !status[s].resp_oflow) else begin
                    errors++;
                    $display("Error: %0d ns: overflow flagged on slice %0d (status %b)",
                             $time, s, status[s]);
                end
            end
        end
    end

    initial begin
        repeat (WD_LIMIT) @(posedge from_controller);
        $display("the run timed out after %0d cycles, %0d of %0d wide acks seen",
                 WD_LIMIT, ack_count, accept_count);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        logic [31:0]       hi;
        logic [31:0]       lo;
        logic [WIDE_W-1:0] data;
        from_controller = 1'b0;
        rst_n           = 1'b0;
        wr_req          = 1'b0;
        wr              = '0;
        rd_addr         = '0;
        seed            = 32'h6439_9473;
        errors          = 0;
        checks          = 0;
        accept_count    = 0;
        ack_count       = 0;
        writes_sent     = 0;
        stall_count     = 0;
        build_table();

        repeat (2) @(negedge from_controller);
        rst_n = 1'b1;
        checks++;
        assert (!wr_ack && status == '0 && !wr_rdy) else begin
            errors++;
            $display("Error: %0d ns: bad reset state, wr_ack %b wr_rdy %b status %b",
                     $time, wr_ack, wr_rdy, status);
        end
        repeat (2) @(negedge from_controller);
        checks++;
        assert (wr_rdy) else begin
            errors++;
            $display("Error: %0d ns: wr_rdy still low after reset", $time);
        end

        for (int i = 0; i < NUM_OPS; i++) begin
            if (ops[i].is_read) begin
                read_check(ops[i].addr);
            end else begin
                data = ops[i].data;
                if (ops[i].rnd) begin
                    hi   = $random(seed);
                    lo   = $random(seed);
                    data = {hi, lo};
                end
                write_word(ops[i].addr, data);
                if (!ops[i].burst) wait_drain();
            end
        end

        wait_drain();
        check_idle_status();
        checks++;
        assert (accept_count == writes_sent && ack_count == writes_sent) else begin
            errors++;
            $display("Error: %0d ns: %0d writes sent, %0d accepted, %0d wide acks",
                     $time, writes_sent, accept_count, ack_count);
        end
        checks++;
        assert (stall_count > 0) else begin
            errors++;
            $display("Error: %0d ns: bursts never saw wr_rdy low", $time);
        end

        $display("checks %0d, errors %0d, writes %0d, wide acks %0d, stall cycles %0d",
                 checks, errors, writes_sent, ack_count, stall_count);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : mem_wr_subsys_tb

//--- source/mem_wr_subsys.sv
/* wide write port split over four slice memories with ack latencies 1 to 4.
   the read port returns the whole wide word one cycle after the address. */
`timescale 1ns/1ps
`include "mem_wr_settings.svh"

module mem_wr_subsys (
    input  logic                                          from_controller,
    input  logic                                          rst_n,
    input  logic                                          wr_req,
    input  mem_wr_pkg::wide_req_t                         wr,
    output logic                                          wr_rdy,
    output logic                                          wr_ack,
    input  mem_wr_pkg::addr_t                             rd_addr,
    output mem_wr_pkg::wide_word_u                        rd_data,
    output mem_wr_pkg::slice_status_t [`MW_N_SLICES-1:0]  status
);
    import mem_wr_pkg::*;

    localparam int N = `MW_N_SLICES;

    slice_req_t [N-1:0]  slice_req;
    logic [N-1:0]        slice_vld;
    logic [N-1:0]        slice_rdy;
    logic [N-1:0]        slice_ack;
    slice_word_t [N-1:0] slice_rd;

    mem_wr_aggregate mem_wr_aggregate_i (
        .from_controller ( from_controller ),
        .rst_n           ( rst_n ),
        .wr_req          ( wr_req ),
        .wr              ( wr ),
        .wr_rdy          ( wr_rdy ),
        .wr_ack          ( wr_ack ),
        .slice_req       ( slice_req ),
        .slice_vld       ( slice_vld ),
        .slice_rdy       ( slice_rdy ),
        .slice_ack       ( slice_ack ),
        .status          ( status )
    );

    // later slices answer more slowly, so acks arrive out of step.
    for (genvar i = 0; i < N; i++) begin : g_slice
        slice_mem #(
            .ACK_LAT ( i + 1 )
        ) slice_mem_i (
            .from_controller ( from_controller ),
            .rst_n           ( rst_n ),
            .req             ( slice_vld[i] ),
            .rdy             ( slice_rdy[i] ),
            .wr              ( slice_req[i] ),
            .ack             ( slice_ack[i] ),
            .rd_addr         ( rd_addr ),
            .rd_data         ( slice_rd[i] )
        );
    end : g_slice

    assign rd_data.slice = slice_rd; // slice 0 in the low bits.

endmodule : mem_wr_subsys

//--- source/slice_mem.sv
/* narrow memory for one slice. takes a write, stays busy for ACK_LAT cycles,
   then pulses ack. the read port is registered. */
`timescale 1ns/1ps

module slice_mem #(
    parameter int ACK_LAT = 1
) (
    input  logic                    from_controller,
    input  logic                    rst_n,
    input  logic                    req,
    output logic                    rdy,
    input  mem_wr_pkg::slice_req_t  wr,
    output logic                    ack,
    input  mem_wr_pkg::addr_t       rd_addr,
    output mem_wr_pkg::slice_word_t rd_data
);
    import mem_wr_pkg::*;

    localparam int WORDS = 2 ** $bits(addr_t);
    localparam int CNT_W = $clog2(ACK_LAT + 1);

    slice_word_t      mem [WORDS];
    logic [CNT_W-1:0] busy_cnt;
    logic             pop;

    assign pop = req && rdy;
    assign rdy = (busy_cnt == '0);
    assign ack = (busy_cnt == CNT_W'(1)); // last busy cycle.

    always_ff @(posedge from_controller or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt <= '0;
        end else if (pop) begin
            busy_cnt <= CNT_W'(ACK_LAT);
        end else if (!rdy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    always_ff @(posedge from_controller) begin
        if (pop) mem[wr.addr] <= wr.data;
        rd_data <= mem[rd_addr];
    end

    // the ack for a pop comes exactly ACK_LAT cycles later.
    a_ack_latency : assert property (
        @(posedge from_controller) disable iff (!rst_n)
        pop |-> ##ACK_LAT ack
    ) else $error("slice_mem: ack out of step with pop");

endmodule : slice_mem

//--- source/mem_wr_aggregate.sv
/* splits each accepted wide write into one request per slice and returns
   one wide ack once every slice has acked its part, in acceptance order. */
`timescale 1ns/1ps
`include "mem_wr_settings.svh"

module mem_wr_aggregate (
    input  logic                                          from_controller,
    input  logic                                          rst_n,
    input  logic                                          wr_req,
    input  mem_wr_pkg::wide_req_t                         wr,
    output logic                                          wr_rdy,
    output logic                                          wr_ack,
    output mem_wr_pkg::slice_req_t [`MW_N_SLICES-1:0]     slice_req,
    output logic [`MW_N_SLICES-1:0]                       slice_vld,
    input  logic [`MW_N_SLICES-1:0]                       slice_rdy,
    input  logic [`MW_N_SLICES-1:0]                       slice_ack,
    output mem_wr_pkg::slice_status_t [`MW_N_SLICES-1:0]  status
);
    import mem_wr_pkg::*;

    localparam int N      = `MW_N_SLICES;
    localparam int OPEN_W = 8;

    logic [N-1:0]      fifo_rdy;
    logic [N-1:0]      pending;
    logic              accept;
    logic [OPEN_W-1:0] open_wr; // accepted wide writes not yet acked.

    // one acceptance, seen by every slice FIFO in the same cycle.
    assign accept = wr_req && wr_rdy;

    for (genvar i = 0; i < N; i++) begin : g_slice
        slice_req_t push;
        logic       req_oflow;
        logic       resp_oflow;

        assign push.addr = wr.addr;
        assign push.data = wr.data.slice[i];

        req_fifo req_fifo_i (
            .from_controller ( from_controller ),
            .rst_n           ( rst_n ),
            .wr              ( accept ),
            .wr_rdy          ( fifo_rdy[i] ),
            .wr_data         ( push ),
            .rd              ( slice_rdy[i] ),
            .rd_vld          ( slice_vld[i] ),
            .rd_data         ( slice_req[i] ),
            .oflow           ( req_oflow )
        );

        ack_align ack_align_i (
            .from_controller ( from_controller ),
            .rst_n           ( rst_n ),
            .inc             ( slice_ack[i] ),
            .dec             ( wr_ack ),
            .nonzero         ( pending[i] ),
            .oflow           ( resp_oflow ),
            .uflow           ( )
        );

        assign status[i] = '{
            req_oflow:    req_oflow,
            req_pending:  slice_vld[i],
            resp_oflow:   resp_oflow,
            resp_pending: pending[i]
        };
    end : g_slice

    // registered, so it trails the FIFO fill by one cycle.
    always_ff @(posedge from_controller or negedge rst_n) begin
        if (!rst_n) begin
            wr_rdy <= 1'b0;
        end else begin
            wr_rdy <= &fifo_rdy;
        end
    end

    assign wr_ack = &pending; // every slice has acked the oldest write.

    always_ff @(posedge from_controller or negedge rst_n) begin
        if (!rst_n) begin
            open_wr <= '0;
        end else if (accept && !wr_ack) begin
            open_wr <= open_wr + 1'b1;
        end else if (wr_ack && !accept) begin
            open_wr <= open_wr - 1'b1;
        end
    end

    // a wide ack needs an earlier acceptance still waiting for its ack.
    a_ack_matched : assert property (
        @(posedge from_controller) disable iff (!rst_n)
        wr_ack |-> (open_wr != '0)
    ) else $error("mem_wr_aggregate: wide ack without a matching write");

endmodule : mem_wr_aggregate

//--- source/ack_align.sv
/* counts slice acks of one slice that still wait for the matching wide ack.
   raised by the slice ack, lowered by the wide ack. */
`timescale 1ns/1ps
`include "mem_wr_settings.svh"

module ack_align (
    input  logic from_controller,
    input  logic rst_n,
    input  logic inc,
    input  logic dec,
    output logic nonzero,
    output logic oflow,
    output logic uflow
);

    localparam int DEPTH = `MW_ALIGN_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [CNT_W-1:0] count;
    logic             at_max;

    assign at_max  = (count == CNT_W'(DEPTH));
    assign nonzero = (count != '0);

    always_ff @(posedge from_controller or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            oflow <= 1'b0;
            uflow <= 1'b0;
        end else begin
            if (inc && !dec) begin
                if (!at_max) count <= count + 1'b1;
            end else if (dec && !inc) begin
                if (nonzero) count <= count - 1'b1;
            end
            if (inc && !dec && at_max) oflow <= 1'b1; // ack lost.
            if (dec && !nonzero) uflow <= 1'b1;
        end
    end

    // the wide ack is formed from every counter, this one included.
    a_no_dec_at_zero : assert property (
        @(posedge from_controller) disable iff (!rst_n) !(dec && !nonzero)
    ) else $error("ack_align: wide ack with no slice ack waiting");

endmodule : ack_align

//--- source/req_fifo.sv
/* prefetch FIFO holding narrow write requests for one slice.
   the head sits in an output register, so a request shows one cycle after its write. */
`timescale 1ns/1ps
`include "mem_wr_settings.svh"

module req_fifo (
    input  logic                   from_controller,
    input  logic                   rst_n,
    input  logic                   wr,
    output logic                   wr_rdy,
    input  mem_wr_pkg::slice_req_t wr_data,
    input  logic                   rd,
    output logic                   rd_vld,
    output mem_wr_pkg::slice_req_t rd_data,
    output logic                   oflow
);
    import mem_wr_pkg::*;

    localparam int DEPTH = `MW_REQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    slice_req_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count; // entries in mem, output stage excluded.
    logic             out_vld;
    logic             full;
    logic             pop;
    logic             out_free;
    logic             mem_wr;
    logic             mem_rd;
    logic             bypass;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(DEPTH));
    assign pop      = rd && out_vld;
    assign out_free = !out_vld || pop;
    assign mem_rd   = out_free && (count != '0);
    assign bypass   = out_free && (count == '0) && wr; // empty, so straight to the head.
    assign mem_wr   = wr && !bypass && !full;

    // two free so the registered ready upstream still has room.
    assign wr_rdy = (count <= CNT_W'(DEPTH - 2));
    assign rd_vld = out_vld;

    always_ff @(posedge from_controller or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            out_vld <= 1'b0;
            oflow   <= 1'b0;
        end else begin
            if (mem_wr) wr_ptr <= ptr_inc(wr_ptr);
            if (mem_rd) rd_ptr <= ptr_inc(rd_ptr);
            if (mem_wr && !mem_rd) begin
                count <= count + 1'b1;
            end else if (mem_rd && !mem_wr) begin
                count <= count - 1'b1;
            end
            if (out_free) out_vld <= mem_rd || bypass;
            if (wr && full) oflow <= 1'b1; // request dropped.
        end
    end

    always_ff @(posedge from_controller) begin
        if (mem_wr) mem[wr_ptr] <= wr_data;
        if (mem_rd) begin
            rd_data <= mem[rd_ptr];
        end else if (bypass) begin
            rd_data <= wr_data;
        end
    end

    // upstream ready lags by a cycle; the spare entry must cover it.
    a_no_write_when_full : assert property (
        @(posedge from_controller) disable iff (!rst_n) !(wr && full)
    ) else $error("req_fifo: write while full");

endmodule : req_fifo

//--- source/mem_wr_pkg.sv
/* types shared by the wide-write aggregator, the slice memories and the testbench. */
`include "mem_wr_settings.svh"

package mem_wr_pkg;

    typedef logic [`MW_ADDR_WID-1:0] addr_t;

    typedef logic [`MW_SLICE_WID-1:0] slice_word_t;

    // one wide data word, either whole or cut into slices. slice 0 is the low bits.
    typedef union packed {
        logic [`MW_N_SLICES*`MW_SLICE_WID-1:0] flat;
        slice_word_t [`MW_N_SLICES-1:0]        slice;
    } wide_word_u;

    // write on the wide port.
    typedef struct packed {
        addr_t      addr;
        wide_word_u data;
    } wide_req_t;

    // write on one narrow slice port.
    typedef struct packed {
        addr_t       addr;
        slice_word_t data;
    } slice_req_t;

    typedef struct packed {
        logic req_oflow;    // sticky.
        logic req_pending;  // slice request presented.
        logic resp_oflow;   // sticky.
        logic resp_pending; // slice ack waiting for the others.
    } slice_status_t;

endpackage : mem_wr_pkg

//--- source/mem_wr_settings.svh
/* sizing for the wide-write split into narrow slices.
   include wherever the widths or depths are needed. */
`ifndef MEM_WR_SETTINGS_SVH
`define MEM_WR_SETTINGS_SVH

// word address width, the same for the wide port and every slice.
`define MW_ADDR_WID 6

// narrow data width of one slice.
`define MW_SLICE_WID 16

`define MW_N_SLICES 4 // slices per wide word.

// request FIFO depth per slice, not counting the output stage.
`define MW_REQ_DEPTH 4

`define MW_ALIGN_DEPTH 8 // slice acks that may wait for the slowest slice.

`endif
